// File: include/cluster_defines.svh
////////////////////////////////////////////////////////////
// Mini cluster sizing: core count, bus and memory widths
// and the peripheral select bit of the word address
////////////////////////////////////////////////////////////

`ifndef CLUSTER_DEFINES_SVH
`define CLUSTER_DEFINES_SVH

// Cores receiving a software interrupt line
`define NR_CORES 4

// Word address and data word widths
`define ADDR_WIDTH 12
`define DATA_WIDTH 32

// TCDM words, indexed by the low address bits
`define MEM_DEPTH 256

// Address bit that routes an access to the peripherals
`define PERIPH_SEL_BIT 11

// Low address bits that pick a peripheral register
`define REG_IDX_WIDTH 3

`endif

// File: verilog/cluster_bus_pkg.sv
////////////////////////////////////////////////////////////
// Bus types shared by the masters, interconnect and memory
////////////////////////////////////////////////////////////

`include "cluster_defines.svh"

package cluster_bus_pkg;

  // Word address and bus data word
  typedef logic [`ADDR_WIDTH-1:0] addr_t;
  typedef logic [`DATA_WIDTH-1:0] data_t;

  // Row index into the TCDM
  typedef logic [$clog2(`MEM_DEPTH)-1:0] mem_idx_t;

  // Bus master that holds the grant
  typedef enum logic {
    HOST = 1'b0,
    DMA  = 1'b1
  } master_e;

endpackage

// File: verilog/cluster_ctrl_pkg.sv
////////////////////////////////////////////////////////////
// Control types: interrupt mask, register map, DMA states
////////////////////////////////////////////////////////////

`include "cluster_defines.svh"

package cluster_ctrl_pkg;

  // One msip bit per core
  typedef logic [`NR_CORES-1:0] core_mask_t;

  // Peripheral register map, word index inside the block
  typedef enum logic [`REG_IDX_WIDTH-1:0] {
    SCRATCH0    = 3'd0,
    SCRATCH1    = 3'd1,
    CLINT_SET   = 3'd2,
    CLINT_CLEAR = 3'd3,
    DMA_SRC     = 3'd4,
    DMA_DST     = 3'd5,
    DMA_LEN     = 3'd6,
    DMA_CTRL    = 3'd7
  } periph_reg_e;

  // Copy engine FSM
  typedef enum logic [1:0] {
    IDLE,
    READ,
    WAIT,
    WRITE
  } dma_state_e;

endpackage

// File: verilog/cluster_interconnect.sv
////////////////////////////////////////////////////////////
// Round-robin arbiter for host and DMA, address decode to
// TCDM or peripherals, and read data return to the master
////////////////////////////////////////////////////////////

`include "cluster_defines.svh"

module cluster_interconnect (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          host_req,
  input  logic                          host_we,
  input  cluster_bus_pkg::addr_t        host_addr,
  input  cluster_bus_pkg::data_t        host_wdata,
  output logic                          host_gnt,
  output logic                          host_rvalid,
  output cluster_bus_pkg::data_t        host_rdata,
  input  logic                          dma_req,
  input  logic                          dma_we,
  input  cluster_bus_pkg::addr_t        dma_addr,
  input  cluster_bus_pkg::data_t        dma_wdata,
  output logic                          dma_gnt,
  output logic                          dma_rvalid,
  output cluster_bus_pkg::data_t        dma_rdata,
  output logic                          mem_en,
  output logic                          mem_we,
  output cluster_bus_pkg::mem_idx_t     mem_idx,
  output cluster_bus_pkg::data_t        mem_wdata,
  input  cluster_bus_pkg::data_t        mem_rdata,
  output logic                          reg_wr,
  output logic                          reg_rd,
  output cluster_ctrl_pkg::periph_reg_e reg_idx,
  output cluster_bus_pkg::data_t        reg_wdata,
  input  cluster_bus_pkg::data_t        reg_rdata
);

  import cluster_bus_pkg::*;
  import cluster_ctrl_pkg::*;

  master_e last_gnt;
  logic    any_gnt;
  logic    sel_we;
  addr_t   sel_addr;
  data_t   sel_wdata;
  logic    to_periph;

  // Outstanding read: owner and responding slave
  logic    rd_pending;
  master_e rd_master;
  logic    rd_periph;
  data_t   rd_data;

  ////////////////////////////////////////////////////////////
  // Arbitration
  ////////////////////////////////////////////////////////////

  // On a conflict the master that lost last time wins
  // No grants while in reset
  assign host_gnt = !rst_n && host_req && (!dma_req || last_gnt == DMA);
  assign dma_gnt  = !rst_n && dma_req && (!host_req || last_gnt == HOST);
  assign any_gnt  = host_gnt || dma_gnt;

  assign sel_we    = host_gnt ? host_we    : dma_we;
  assign sel_addr  = host_gnt ? host_addr  : dma_addr;
  assign sel_wdata = host_gnt ? host_wdata : dma_wdata;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      last_gnt <= DMA;
    end else if (any_gnt) begin
      last_gnt <= host_gnt ? HOST : DMA;
    end
  end

  ////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////

  assign to_periph = sel_addr[`PERIPH_SEL_BIT];

  // Memory ignores the upper address bits, so it aliases
  assign mem_en    = any_gnt && !to_periph;
  assign mem_we    = sel_we;
  assign mem_idx   = mem_idx_t'(sel_addr);
  assign mem_wdata = sel_wdata;

  assign reg_wr    = any_gnt && to_periph && sel_we;
  assign reg_rd    = any_gnt && to_periph && !sel_we;
  assign reg_idx   = periph_reg_e'(sel_addr[`REG_IDX_WIDTH-1:0]);
  assign reg_wdata = sel_wdata;

  ////////////////////////////////////////////////////////////
  // Read response
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_n) begin
      rd_pending <= 1'b0;
      rd_master  <= HOST;
      rd_periph  <= 1'b0;
    end else begin
      rd_pending <= any_gnt && !sel_we;
      if (any_gnt) begin
        rd_master <= host_gnt ? HOST : DMA;
        rd_periph <= to_periph;
      end
    end
  end

  // Both slaves answer one cycle after the request
  assign rd_data = rd_periph ? reg_rdata : mem_rdata;

  assign host_rvalid = rd_pending && (rd_master == HOST);
  assign dma_rvalid  = rd_pending && (rd_master == DMA);
  assign host_rdata  = rd_data;
  assign dma_rdata   = rd_data;

endmodule

// File: verilog/tcdm_sram.sv
////////////////////////////////////////////////////////////
// Single-port TCDM with a registered read port
////////////////////////////////////////////////////////////

`include "cluster_defines.svh"

module tcdm_sram (
  input  logic                      clk,
  input  logic                      mem_en,
  input  logic                      mem_we,
  input  cluster_bus_pkg::mem_idx_t mem_idx,
  input  cluster_bus_pkg::data_t    mem_wdata,
  output cluster_bus_pkg::data_t    mem_rdata
);

  import cluster_bus_pkg::*;

  data_t mem [`MEM_DEPTH];

  // Read data appears the cycle after the access
  always_ff @(posedge clk) begin
    if (mem_en) begin
      if (mem_we) begin
        mem[mem_idx] <= mem_wdata;
      end else begin
        mem_rdata <= mem[mem_idx];
      end
    end
  end

endmodule

// File: verilog/cluster_dma.sv
////////////////////////////////////////////////////////////
// Word-by-word copy engine, one read then one write per
// word, both issued as a bus master on the interconnect
////////////////////////////////////////////////////////////

`include "cluster_defines.svh"

module cluster_dma (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   dma_start,
  input  cluster_bus_pkg::addr_t dma_src,
  input  cluster_bus_pkg::addr_t dma_dst,
  input  cluster_bus_pkg::data_t dma_len,
  output logic                   dma_busy,
  output logic                   dma_req,
  output logic                   dma_we,
  output cluster_bus_pkg::addr_t dma_addr,
  output cluster_bus_pkg::data_t dma_wdata,
  input  logic                   dma_gnt,
  input  logic                   dma_rvalid,
  input  cluster_bus_pkg::data_t dma_rdata
);

  import cluster_bus_pkg::*;
  import cluster_ctrl_pkg::*;

  dma_state_e state;
  addr_t      src_q;
  addr_t      dst_q;
  data_t      cnt_q;
  data_t      buf_q;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state <= IDLE;
      src_q <= '0;
      dst_q <= '0;
      cnt_q <= '0;
      buf_q <= '0;
    end else begin
      case (state)
        IDLE: begin
          // Zero length copies nothing and never goes busy
          if (dma_start && dma_len != '0) begin
            src_q <= dma_src;
            dst_q <= dma_dst;
            cnt_q <= dma_len;
            state <= READ;
          end
        end
        READ: begin
          if (dma_gnt) begin
            state <= WAIT;
          end
        end
        WAIT: begin
          if (dma_rvalid) begin
            buf_q <= dma_rdata;
            state <= WRITE;
          end
        end
        WRITE: begin
          if (dma_gnt) begin
            src_q <= src_q + addr_t'(1);
            dst_q <= dst_q + addr_t'(1);
            cnt_q <= cnt_q - data_t'(1);
            // Last word written
            state <= (cnt_q == data_t'(1)) ? IDLE : READ;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign dma_busy = (state != IDLE);

  // Request held in READ and WRITE until granted
  always_comb begin
    dma_req   = 1'b0;
    dma_we    = 1'b0;
    dma_addr  = src_q;
    dma_wdata = buf_q;
    case (state)
      READ: begin
        dma_req = 1'b1;
      end
      WRITE: begin
        dma_req  = 1'b1;
        dma_we   = 1'b1;
        dma_addr = dst_q;
      end
      default: ;
    endcase
  end

endmodule

// File: verilog/cluster_periph.sv
////////////////////////////////////////////////////////////
// Cluster peripherals: scratch words, software interrupt
// set/clear register, DMA configuration and status
////////////////////////////////////////////////////////////

`include "cluster_defines.svh"

module cluster_periph (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          reg_wr,
  input  logic                          reg_rd,
  input  cluster_ctrl_pkg::periph_reg_e reg_idx,
  input  cluster_bus_pkg::data_t        reg_wdata,
  output cluster_bus_pkg::data_t        reg_rdata,
  output cluster_ctrl_pkg::core_mask_t  msip,
  output logic                          dma_start,
  output cluster_bus_pkg::addr_t        dma_src,
  output cluster_bus_pkg::addr_t        dma_dst,
  output cluster_bus_pkg::data_t        dma_len,
  input  logic                          dma_busy
);

  import cluster_bus_pkg::*;
  import cluster_ctrl_pkg::*;

  data_t      scratch0;
  data_t      scratch1;
  core_mask_t msip_q;
  addr_t      src_q;
  addr_t      dst_q;
  data_t      len_q;
  data_t      rd_mux;

  ////////////////////////////////////////////////////////////
  // Register writes
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_n) begin
      scratch0 <= '0;
      scratch1 <= '0;
      msip_q   <= '0;
      src_q    <= '0;
      dst_q    <= '0;
      len_q    <= '0;
    end else if (reg_wr) begin
      case (reg_idx)
        SCRATCH0:    scratch0 <= reg_wdata;
        SCRATCH1:    scratch1 <= reg_wdata;
        // Set and clear aliases of the same mask
        CLINT_SET:   msip_q <= msip_q | reg_wdata[`NR_CORES-1:0];
        CLINT_CLEAR: msip_q <= msip_q & ~reg_wdata[`NR_CORES-1:0];
        DMA_SRC:     src_q <= reg_wdata[`ADDR_WIDTH-1:0];
        DMA_DST:     dst_q <= reg_wdata[`ADDR_WIDTH-1:0];
        DMA_LEN:     len_q <= reg_wdata;
        default: ;
      endcase
    end
  end

  // Start strobe in the grant cycle, so the next read already sees busy
  assign dma_start = reg_wr && (reg_idx == DMA_CTRL);

  assign msip    = msip_q;
  assign dma_src = src_q;
  assign dma_dst = dst_q;
  assign dma_len = len_q;

  ////////////////////////////////////////////////////////////
  // Register reads
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (reg_idx)
      SCRATCH0:    rd_mux = scratch0;
      SCRATCH1:    rd_mux = scratch1;
      CLINT_SET,
      CLINT_CLEAR: rd_mux = data_t'(msip_q);
      DMA_SRC:     rd_mux = data_t'(src_q);
      DMA_DST:     rd_mux = data_t'(dst_q);
      DMA_LEN:     rd_mux = len_q;
      DMA_CTRL:    rd_mux = data_t'(dma_busy);
      default:     rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      reg_rdata <= '0;
    end else if (reg_rd) begin
      reg_rdata <= rd_mux;
    end
  end

endmodule

// File: verilog/mini_cluster_top.sv
////////////////////////////////////////////////////////////
// Mini cluster top: interconnect, TCDM, DMA, peripherals
////////////////////////////////////////////////////////////

`include "cluster_defines.svh"

module mini_cluster_top (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         host_req,
  input  logic                         host_we,
  input  cluster_bus_pkg::addr_t       host_addr,
  input  cluster_bus_pkg::data_t       host_wdata,
  output logic                         host_gnt,
  output logic                         host_rvalid,
  output cluster_bus_pkg::data_t       host_rdata,
  output cluster_ctrl_pkg::core_mask_t msip
);

  import cluster_bus_pkg::*;
  import cluster_ctrl_pkg::*;

  // DMA master port
  logic  dma_req;
  logic  dma_we;
  addr_t dma_addr;
  data_t dma_wdata;
  logic  dma_gnt;
  logic  dma_rvalid;
  data_t dma_rdata;

  // TCDM port
  logic     mem_en;
  logic     mem_we;
  mem_idx_t mem_idx;
  data_t    mem_wdata;
  data_t    mem_rdata;

  // Peripheral port
  logic        reg_wr;
  logic        reg_rd;
  periph_reg_e reg_idx;
  data_t       reg_wdata;
  data_t       reg_rdata;

  // DMA control
  logic  dma_start;
  logic  dma_busy;
  addr_t dma_src;
  addr_t dma_dst;
  data_t dma_len;

  cluster_interconnect u_interconnect (
    .clk         (clk),
    .rst_n       (rst_n),
    .host_req    (host_req),
    .host_we     (host_we),
    .host_addr   (host_addr),
    .host_wdata  (host_wdata),
    .host_gnt    (host_gnt),
    .host_rvalid (host_rvalid),
    .host_rdata  (host_rdata),
    .dma_req     (dma_req),
    .dma_we      (dma_we),
    .dma_addr    (dma_addr),
    .dma_wdata   (dma_wdata),
    .dma_gnt     (dma_gnt),
    .dma_rvalid  (dma_rvalid),
    .dma_rdata   (dma_rdata),
    .mem_en      (mem_en),
    .mem_we      (mem_we),
    .mem_idx     (mem_idx),
    .mem_wdata   (mem_wdata),
    .mem_rdata   (mem_rdata),
    .reg_wr      (reg_wr),
    .reg_rd      (reg_rd),
    .reg_idx     (reg_idx),
    .reg_wdata   (reg_wdata),
    .reg_rdata   (reg_rdata)
  );

  tcdm_sram u_sram (
    .clk       (clk),
    .mem_en    (mem_en),
    .mem_we    (mem_we),
    .mem_idx   (mem_idx),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
  );

  cluster_dma u_dma (
    .clk        (clk),
    .rst_n      (rst_n),
    .dma_start  (dma_start),
    .dma_src    (dma_src),
    .dma_dst    (dma_dst),
    .dma_len    (dma_len),
    .dma_busy   (dma_busy),
    .dma_req    (dma_req),
    .dma_we     (dma_we),
    .dma_addr   (dma_addr),
    .dma_wdata  (dma_wdata),
    .dma_gnt    (dma_gnt),
    .dma_rvalid (dma_rvalid),
    .dma_rdata  (dma_rdata)
  );

  cluster_periph u_periph (
    .clk       (clk),
    .rst_n     (rst_n),
    .reg_wr    (reg_wr),
    .reg_rd    (reg_rd),
    .reg_idx   (reg_idx),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .msip      (msip),
    .dma_start (dma_start),
    .dma_src   (dma_src),
    .dma_dst   (dma_dst),
    .dma_len   (dma_len),
    .dma_busy  (dma_busy)
  );

endmodule

// File: test/cluster_properties.sv
////////////////////////////////////////////////////////////
// Interconnect checks: single grant, read data timing
////////////////////////////////////////////////////////////

module cluster_properties (
  input logic clk,
  input logic rst_n,
  input logic host_we,
  input logic host_gnt,
  input logic host_rvalid,
  input logic dma_we,
  input logic dma_gnt,
  input logic dma_rvalid
);

  timeunit 1ns;
  timeprecision 1ps;

  // One master on the bus per cycle
  a_one_grant: assert property (@(posedge clk) disable iff (rst_n)
    !(host_gnt && dma_gnt))
    else $error("host and DMA granted in the same cycle");

  // Granted reads answer exactly one cycle later
  a_host_rvalid: assert property (@(posedge clk) disable iff (rst_n)
    host_gnt && !host_we |=> host_rvalid)
    else $error("host read grant not followed by host_rvalid");

  a_dma_rvalid: assert property (@(posedge clk) disable iff (rst_n)
    dma_gnt && !dma_we |=> dma_rvalid)
    else $error("DMA read grant not followed by dma_rvalid");

  // No response without a read granted the cycle before
  a_host_no_stray: assert property (@(posedge clk) disable iff (rst_n)
    host_rvalid |-> $past(host_gnt && !host_we))
    else $error("host_rvalid without a granted host read");

  a_dma_no_stray: assert property (@(posedge clk) disable iff (rst_n)
    dma_rvalid |-> $past(dma_gnt && !dma_we))
    else $error("dma_rvalid without a granted DMA read");

endmodule

bind cluster_interconnect cluster_properties u_props (
  .clk         (clk),
  .rst_n       (rst_n),
  .host_we     (host_we),
  .host_gnt    (host_gnt),
  .host_rvalid (host_rvalid),
  .dma_we      (dma_we),
  .dma_gnt     (dma_gnt),
  .dma_rvalid  (dma_rvalid)
);

// File: test/tb_mini_cluster.sv
////////////////////////////////////////////////////////////
// Mini cluster testbench: host accesses to TCDM, scratch,
// software interrupt and DMA registers
////////////////////////////////////////////////////////////

`include "cluster_defines.svh"

module tb_mini_cluster;

  timeunit 1ns;
  timeprecision 1ps;

  import cluster_bus_pkg::*;
  import cluster_ctrl_pkg::*;

  localparam int CLK_PERIOD  = 10;
  localparam int WATCHDOG_NS = 20000;
  localparam int MAX_POLLS   = 100;

  logic       clk;
  logic       rst_n;
  logic       host_req;
  logic       host_we;
  addr_t      host_addr;
  data_t      host_wdata;
  logic       host_gnt;
  logic       host_rvalid;
  data_t      host_rdata;
  core_mask_t msip;

  int errors;
  int seed;

  mini_cluster_top u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .host_req    (host_req),
    .host_we     (host_we),
    .host_addr   (host_addr),
    .host_wdata  (host_wdata),
    .host_gnt    (host_gnt),
    .host_rvalid (host_rvalid),
    .host_rdata  (host_rdata),
    .msip        (msip)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #WATCHDOG_NS;
    $display("Watchdog expired before the tests finished");
    $display("STATUS: FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Compare tasks and host bus access
  ////////////////////////////////////////////////////////////

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_mask(input string name, input core_mask_t got, input core_mask_t exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got 0x%01h expected 0x%01h", name, got, exp);
    end
  endtask

  // Peripheral select bit plus register index
  function automatic addr_t periph_addr(input periph_reg_e idx);
    addr_t a;
    a = '0;
    a[`PERIPH_SEL_BIT] = 1'b1;
    a[`REG_IDX_WIDTH-1:0] = idx;
    return a;
  endfunction

  // Called and returns at 1 ns after a rising edge
  task automatic host_write(input addr_t addr, input data_t data);
    host_req   = 1'b1;
    host_we    = 1'b1;
    host_addr  = addr;
    host_wdata = data;
    @(negedge clk);
    while (!host_gnt) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    host_req = 1'b0;
    host_we  = 1'b0;
  endtask

  task automatic host_read(input addr_t addr, output data_t data);
    host_req  = 1'b1;
    host_we   = 1'b0;
    host_addr = addr;
    @(negedge clk);
    while (!host_gnt) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    host_req = 1'b0;
    @(negedge clk);
    if (!host_rvalid) begin
      errors++;
      $display("Host read of 0x%03h got no rvalid one cycle after its grant", addr);
    end
    data = host_rdata;
    @(posedge clk);
    #1;
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    data_t rd;
    check_mask("msip", msip, '0);
    if (host_gnt !== 1'b0) begin
      errors++;
      $display("mismatch host_gnt: got 0x%01h expected 0x0", host_gnt);
    end
    host_read(periph_addr(CLINT_SET), rd);
    check_data("clint_set", rd, '0);
  endtask

  task automatic test_memory();
    data_t exp [16];
    data_t rd;
    data_t alias_val;
    for (int i = 0; i < 16; i++) begin
      exp[i] = $random(seed);
      host_write(addr_t'(i * 4), exp[i]);
    end
    for (int i = 0; i < 16; i++) begin
      host_read(addr_t'(i * 4), rd);
      check_data("mem_rdata", rd, exp[i]);
    end
    // 0x110 lands on the same row as 0x010
    alias_val = $random(seed);
    host_write(12'h110, alias_val);
    host_read(12'h010, rd);
    check_data("mem_alias", rd, alias_val);
  endtask

  task automatic test_scratch();
    data_t val0;
    data_t val1;
    data_t rd;
    val0 = $random(seed);
    val1 = $random(seed);
    host_write(periph_addr(SCRATCH0), val0);
    host_write(periph_addr(SCRATCH1), val1);
    host_read(periph_addr(SCRATCH0), rd);
    check_data("scratch0", rd, val0);
    host_read(periph_addr(SCRATCH1), rd);
    check_data("scratch1", rd, val1);
  endtask

  task automatic clint_write(input bit set, input core_mask_t mask,
                             inout core_mask_t model);
    data_t rd;
    if (set) begin
      host_write(periph_addr(CLINT_SET), data_t'(mask));
      model = model | mask;
    end else begin
      host_write(periph_addr(CLINT_CLEAR), data_t'(mask));
      model = model & ~mask;
    end
    check_mask("msip", msip, model);
    host_read(periph_addr(CLINT_CLEAR), rd);
    check_data("clint_rdata", rd, data_t'(model));
  endtask

  task automatic test_clint();
    core_mask_t model;
    model = '0;
    clint_write(1'b1, 4'h1, model);
    clint_write(1'b1, 4'h4, model);
    clint_write(1'b0, 4'h1, model);
    clint_write(1'b1, 4'ha, model);
    clint_write(1'b0, 4'hf, model);
  endtask

  task automatic test_dma_copy();
    data_t src [8];
    data_t sentinel;
    data_t rd;
    int    polls;
    for (int i = 0; i < 8; i++) begin
      src[i] = $random(seed);
      host_write(addr_t'(12'h040 + i), src[i]);
    end
    sentinel = $random(seed);
    host_write(12'h088, sentinel);
    host_write(periph_addr(DMA_SRC), 32'h040);
    host_write(periph_addr(DMA_DST), 32'h080);
    host_write(periph_addr(DMA_LEN), 32'd8);
    host_write(periph_addr(DMA_CTRL), 32'd1);
    // Polls share the bus with the running copy
    polls = 0;
    do begin
      host_read(periph_addr(DMA_CTRL), rd);
      polls++;
      if (polls == 1) begin
        check_data("dma_ctrl", rd, 32'd1);
      end
    end while (rd[0] && polls < MAX_POLLS);
    if (rd[0]) begin
      errors++;
      $display("DMA still busy after %0d status polls", polls);
    end
    for (int i = 0; i < 8; i++) begin
      host_read(addr_t'(12'h080 + i), rd);
      check_data("dma_dst", rd, src[i]);
    end
    host_read(12'h088, rd);
    check_data("dma_past_end", rd, sentinel);
  endtask

  task automatic test_dma_zero_len();
    data_t keep;
    data_t rd;
    keep = $random(seed);
    host_write(12'h0c0, keep);
    host_write(periph_addr(DMA_SRC), 32'h040);
    host_write(periph_addr(DMA_DST), 32'h0c0);
    host_write(periph_addr(DMA_LEN), 32'd0);
    host_write(periph_addr(DMA_CTRL), 32'd1);
    host_read(periph_addr(DMA_CTRL), rd);
    check_data("dma_ctrl", rd, 32'd0);
    host_read(12'h0c0, rd);
    check_data("dma_zero_dst", rd, keep);
  endtask

  initial begin
    errors     = 0;
    seed       = 32'h43f;
    rst_n      = 1'b1;
    host_req   = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b0;

    test_reset_state();
    test_memory();
    test_scratch();
    test_clint();
    test_dma_copy();
    test_dma_zero_len();

    $display("Tests finished with %0d errors", errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+include
verilog/cluster_bus_pkg.sv
verilog/cluster_ctrl_pkg.sv
verilog/cluster_interconnect.sv
verilog/tcdm_sram.sv
verilog/cluster_dma.sv
verilog/cluster_periph.sv
verilog/mini_cluster_top.sv
test/cluster_properties.sv
test/tb_mini_cluster.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the mini cluster testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f build.f --top-module tb_mini_cluster -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if grep -qx "STATUS: PASS" <<< "$out"; then
  exit 0
fi
exit 1
